//--- hdl/csr_pkg.sv
package csr_pkg;

    localparam int CSR_W      = 32;
    localparam int ADDR_W     = 14;
    localparam int ECODE_W    = 6;
    localparam int ESUBCODE_W = 9;
    localparam int SAVE_N     = 4;

    // Register numbers
    typedef enum logic [ADDR_W-1:0] {
        CSR_CRMD   = 14'h000,
        CSR_PRMD   = 14'h001,
        CSR_ECFG   = 14'h004,
        CSR_ESTAT  = 14'h005,
        CSR_ERA    = 14'h006,
        CSR_EENTRY = 14'h00c,
        CSR_SAVE0  = 14'h030,
        CSR_SAVE1  = 14'h031,
        CSR_SAVE2  = 14'h032,
        CSR_SAVE3  = 14'h033,
        CSR_TID    = 14'h040,
        CSR_TCFG   = 14'h041,
        CSR_TVAL   = 14'h042,
        CSR_TICLR  = 14'h044
    } csr_addr_e;

    // Field positions
    localparam int CRMD_PLV_HI       = 1;
    localparam int CRMD_PLV_LO       = 0;
    localparam int CRMD_IE           = 2;
    localparam int PRMD_PPLV_HI      = 1;
    localparam int PRMD_PPLV_LO      = 0;
    localparam int PRMD_PIE          = 2;
    localparam int ECFG_LIE_HI       = 12;
    localparam int ECFG_LIE_LO       = 0;
    localparam int ESTAT_IS_HI       = 12;
    localparam int ESTAT_IS_LO       = 0;
    localparam int ESTAT_ECODE_HI    = 21;
    localparam int ESTAT_ECODE_LO    = 16;
    localparam int ESTAT_ESUBCODE_HI = 30;
    localparam int ESTAT_ESUBCODE_LO = 22;
    localparam int EENTRY_VA_HI      = 31;
    localparam int EENTRY_VA_LO      = 6;
    localparam int TCFG_EN           = 0;
    localparam int TCFG_PERIODIC     = 1;
    localparam int TCFG_INITVAL_HI   = 31;
    localparam int TCFG_INITVAL_LO   = 2;
    localparam int TICLR_CLR         = 0;
    localparam int TI_BIT            = 11;
    localparam int SWI_HI            = 1;
    localparam int SWI_LO            = 0;

    // Timer rests here when stopped
    localparam logic [CSR_W-1:0] TVAL_IDLE = '1;

    typedef struct packed {
        logic             we;
        csr_addr_e        addr;
        logic [CSR_W-1:0] mask;
        logic [CSR_W-1:0] data;
    } csr_wr_t;

    typedef struct packed {
        logic                  exc;
        logic                  ertn;
        logic [ECODE_W-1:0]    ecode;
        logic [ESUBCODE_W-1:0] esubcode;
        logic [CSR_W-1:0]      pc;
    } exc_evt_t;

    typedef struct packed {
        logic [CSR_W-1:0]             crmd;
        logic [CSR_W-1:0]             prmd;
        logic [CSR_W-1:0]             ecfg;
        logic [CSR_W-1:0]             estat_hi;
        logic [CSR_W-1:0]             era;
        logic [CSR_W-1:0]             eentry;
        logic [SAVE_N-1:0][CSR_W-1:0] save;
    } exc_view_t;

    typedef struct packed {
        logic [CSR_W-1:0] tid;
        logic [CSR_W-1:0] tcfg;
        logic [CSR_W-1:0] tval;
        logic             ti;
    } timer_view_t;

    // Bits under a set mask take new data
    function automatic logic [CSR_W-1:0] wmerge(
        input logic [CSR_W-1:0] old,
        input logic [CSR_W-1:0] mask,
        input logic [CSR_W-1:0] data
    );
        return (mask & data) | (~mask & old);
    endfunction

endpackage

//--- hdl/csr_exc_regs.sv
module csr_exc_regs (
    input  logic               clk,
    input  logic               resetn,
    input  csr_pkg::csr_wr_t   wr,
    input  csr_pkg::exc_evt_t  evt,
    output csr_pkg::exc_view_t view,
    output logic [1:0]         swi
);

    logic [1:0]                              crmd_plv;
    logic                                    crmd_ie;
    logic [1:0]                              prmd_pplv;
    logic                                    prmd_pie;
    logic [12:0]                             ecfg_lie;
    logic [1:0]                              estat_swi;
    logic [csr_pkg::ECODE_W-1:0]             estat_ecode;
    logic [csr_pkg::ESUBCODE_W-1:0]          estat_esubcode;
    logic [csr_pkg::CSR_W-1:0]               era;
    logic [25:0]                             eentry_va;
    logic [csr_pkg::SAVE_N-1:0][csr_pkg::CSR_W-1:0] save;

    logic wr_crmd;
    logic wr_prmd;
    logic wr_ecfg;
    logic wr_estat;
    logic wr_era;
    logic wr_eentry;

    logic [csr_pkg::CSR_W-1:0] crmd_wr;
    logic [csr_pkg::CSR_W-1:0] prmd_wr;
    logic [csr_pkg::CSR_W-1:0] ecfg_wr;
    logic [csr_pkg::CSR_W-1:0] estat_wr;
    logic [csr_pkg::CSR_W-1:0] era_wr;
    logic [csr_pkg::CSR_W-1:0] eentry_wr;

    assign wr_crmd   = wr.we && (wr.addr == csr_pkg::CSR_CRMD);
    assign wr_prmd   = wr.we && (wr.addr == csr_pkg::CSR_PRMD);
    assign wr_ecfg   = wr.we && (wr.addr == csr_pkg::CSR_ECFG);
    assign wr_estat  = wr.we && (wr.addr == csr_pkg::CSR_ESTAT);
    assign wr_era    = wr.we && (wr.addr == csr_pkg::CSR_ERA);
    assign wr_eentry = wr.we && (wr.addr == csr_pkg::CSR_EENTRY);

    // Merge against the current read images
    assign crmd_wr   = csr_pkg::wmerge(view.crmd, wr.mask, wr.data);
    assign prmd_wr   = csr_pkg::wmerge(view.prmd, wr.mask, wr.data);
    assign ecfg_wr   = csr_pkg::wmerge(view.ecfg, wr.mask, wr.data);
    assign estat_wr  = csr_pkg::wmerge(32'(estat_swi), wr.mask, wr.data);
    assign era_wr    = csr_pkg::wmerge(view.era, wr.mask, wr.data);
    assign eentry_wr = csr_pkg::wmerge(view.eentry, wr.mask, wr.data);

    // Exception clears privilege, return restores it
    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (evt.exc) begin
            crmd_plv <= 2'b0;
            crmd_ie  <= 1'b0;
        end else if (evt.ertn) begin
            crmd_plv <= prmd_pplv;
            crmd_ie  <= prmd_pie;
        end else if (wr_crmd) begin
            crmd_plv <= crmd_wr[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO];
            crmd_ie  <= crmd_wr[csr_pkg::CRMD_IE];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            prmd_pplv <= 2'b0;
            prmd_pie  <= 1'b0;
        end else if (evt.exc) begin
            prmd_pplv <= crmd_plv;
            prmd_pie  <= crmd_ie;
        end else if (wr_prmd) begin
            prmd_pplv <= prmd_wr[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO];
            prmd_pie  <= prmd_wr[csr_pkg::PRMD_PIE];
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            ecfg_lie  <= '0;
            estat_swi <= 2'b0;
        end else begin
            if (wr_ecfg) begin
                ecfg_lie <= ecfg_wr[csr_pkg::ECFG_LIE_HI:csr_pkg::ECFG_LIE_LO];
            end
            // Software interrupts set only by direct write
            if (wr_estat) begin
                estat_swi <= estat_wr[csr_pkg::SWI_HI:csr_pkg::SWI_LO];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            estat_ecode    <= '0;
            estat_esubcode <= '0;
            era            <= '0;
        end else if (evt.exc) begin
            estat_ecode    <= evt.ecode;
            estat_esubcode <= evt.esubcode;
            era            <= evt.pc;
        end else if (wr_era) begin
            era <= era_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            eentry_va <= '0;
        end else if (wr_eentry) begin
            eentry_va <= eentry_wr[csr_pkg::EENTRY_VA_HI:csr_pkg::EENTRY_VA_LO];
        end
    end

    // Scratch registers
    always_ff @(posedge clk) begin
        if (!resetn) begin
            save <= '0;
        end else begin
            for (int i = 0; i < csr_pkg::SAVE_N; i++) begin
                if (wr.we && wr.addr == csr_pkg::csr_addr_e'(csr_pkg::CSR_SAVE0 + i)) begin
                    save[i] <= csr_pkg::wmerge(save[i], wr.mask, wr.data);
                end
            end
        end
    end

    always_comb begin
        view = '0;
        view.crmd[csr_pkg::CRMD_PLV_HI:csr_pkg::CRMD_PLV_LO]       = crmd_plv;
        view.crmd[csr_pkg::CRMD_IE]                                = crmd_ie;
        view.prmd[csr_pkg::PRMD_PPLV_HI:csr_pkg::PRMD_PPLV_LO]     = prmd_pplv;
        view.prmd[csr_pkg::PRMD_PIE]                               = prmd_pie;
        view.ecfg[csr_pkg::ECFG_LIE_HI:csr_pkg::ECFG_LIE_LO]       = ecfg_lie;
        view.estat_hi[csr_pkg::ESTAT_ECODE_HI:csr_pkg::ESTAT_ECODE_LO] = estat_ecode;
        view.estat_hi[csr_pkg::ESTAT_ESUBCODE_HI:csr_pkg::ESTAT_ESUBCODE_LO] = estat_esubcode;
        view.era                                                   = era;
        view.eentry[csr_pkg::EENTRY_VA_HI:csr_pkg::EENTRY_VA_LO]   = eentry_va;
        view.save                                                  = save;
    end

    assign swi = estat_swi;

endmodule

//--- hdl/csr_timer.sv
module csr_timer (
    input  logic                 clk,
    input  logic                 resetn,
    input  csr_pkg::csr_wr_t     wr,
    output csr_pkg::timer_view_t view
);

    logic [csr_pkg::CSR_W-1:0] tid;
    logic                      tcfg_en;
    logic                      tcfg_periodic;
    logic [29:0]               tcfg_initval;
    logic [csr_pkg::CSR_W-1:0] tval;
    logic                      ti;

    logic                      wr_tid;
    logic                      wr_tcfg;
    logic                      ticlr_hit;
    logic [csr_pkg::CSR_W-1:0] tcfg_img;
    logic [csr_pkg::CSR_W-1:0] tcfg_wr;
    logic                      tval_zero;

    assign wr_tid    = wr.we && (wr.addr == csr_pkg::CSR_TID);
    assign wr_tcfg   = wr.we && (wr.addr == csr_pkg::CSR_TCFG);
    assign ticlr_hit = wr.we && (wr.addr == csr_pkg::CSR_TICLR)
                       && wr.mask[csr_pkg::TICLR_CLR] && wr.data[csr_pkg::TICLR_CLR];

    assign tcfg_img  = {tcfg_initval, tcfg_periodic, tcfg_en};
    assign tcfg_wr   = csr_pkg::wmerge(tcfg_img, wr.mask, wr.data);
    assign tval_zero = (tval == '0);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tid <= '0;
        end else if (wr_tid) begin
            tid <= csr_pkg::wmerge(tid, wr.mask, wr.data);
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            tcfg_en       <= 1'b0;
            tcfg_periodic <= 1'b0;
            tcfg_initval  <= '0;
        end else if (wr_tcfg) begin
            tcfg_en       <= tcfg_wr[csr_pkg::TCFG_EN];
            tcfg_periodic <= tcfg_wr[csr_pkg::TCFG_PERIODIC];
            tcfg_initval  <= tcfg_wr[csr_pkg::TCFG_INITVAL_HI:csr_pkg::TCFG_INITVAL_LO];
        end
    end

    // Load on enabling write, then count down to idle
    always_ff @(posedge clk) begin
        if (!resetn) begin
            tval <= csr_pkg::TVAL_IDLE;
        end else if (wr_tcfg && tcfg_wr[csr_pkg::TCFG_EN]) begin
            tval <= {tcfg_wr[csr_pkg::TCFG_INITVAL_HI:csr_pkg::TCFG_INITVAL_LO], 2'b00};
        end else if (tcfg_en && tval != csr_pkg::TVAL_IDLE) begin
            if (tval_zero && tcfg_periodic) begin
                tval <= {tcfg_initval, 2'b00};
            end else begin
                tval <= tval - 1'b1;
            end
        end
    end

    // Set beats clear
    always_ff @(posedge clk) begin
        if (!resetn) begin
            ti <= 1'b0;
        end else if (tcfg_en && tval_zero) begin
            ti <= 1'b1;
        end else if (ticlr_hit) begin
            ti <= 1'b0;
        end
    end

    assign view.tid  = tid;
    assign view.tcfg = tcfg_img;
    assign view.tval = tval;
    assign view.ti   = ti;

endmodule

//--- hdl/csr_read_mux.sv
module csr_read_mux (
    input  csr_pkg::csr_addr_e        raddr,
    input  csr_pkg::exc_view_t        exc,
    input  logic [1:0]                swi,
    input  csr_pkg::timer_view_t      tmr,
    output logic [csr_pkg::CSR_W-1:0] rdata,
    output logic                      has_int
);

    logic [csr_pkg::CSR_W-1:0] estat;
    logic [csr_pkg::TI_BIT:0]  int_pend;

    // Hardware lines and IPI stay zero
    always_comb begin
        estat                                  = exc.estat_hi;
        estat[csr_pkg::SWI_HI:csr_pkg::SWI_LO] = swi;
        estat[csr_pkg::TI_BIT]                 = tmr.ti;
    end

    // Only IS[11:0] can interrupt
    assign int_pend = estat[csr_pkg::TI_BIT:csr_pkg::ESTAT_IS_LO]
                      & exc.ecfg[csr_pkg::TI_BIT:csr_pkg::ECFG_LIE_LO];

    assign has_int = (|int_pend) && exc.crmd[csr_pkg::CRMD_IE];

    always_comb begin
        case (raddr)
            csr_pkg::CSR_CRMD:   rdata = exc.crmd;
            csr_pkg::CSR_PRMD:   rdata = exc.prmd;
            csr_pkg::CSR_ECFG:   rdata = exc.ecfg;
            csr_pkg::CSR_ESTAT:  rdata = estat;
            csr_pkg::CSR_ERA:    rdata = exc.era;
            csr_pkg::CSR_EENTRY: rdata = exc.eentry;
            csr_pkg::CSR_SAVE0:  rdata = exc.save[0];
            csr_pkg::CSR_SAVE1:  rdata = exc.save[1];
            csr_pkg::CSR_SAVE2:  rdata = exc.save[2];
            csr_pkg::CSR_SAVE3:  rdata = exc.save[3];
            csr_pkg::CSR_TID:    rdata = tmr.tid;
            csr_pkg::CSR_TCFG:   rdata = tmr.tcfg;
            csr_pkg::CSR_TVAL:   rdata = tmr.tval;
            // Write-only clear register
            csr_pkg::CSR_TICLR:  rdata = '0;
            default:             rdata = '0;
        endcase
    end

endmodule

//--- hdl/csr_unit.sv
module csr_unit (
    input  logic                      clk,
    input  logic                      resetn,
    input  csr_pkg::csr_wr_t          wr,
    input  csr_pkg::exc_evt_t         evt,
    input  csr_pkg::csr_addr_e        raddr,
    output logic [csr_pkg::CSR_W-1:0] rdata,
    output logic                      has_int,
    output logic [csr_pkg::CSR_W-1:0] exc_entaddr,
    output logic [csr_pkg::CSR_W-1:0] exc_retaddr
);

    csr_pkg::exc_view_t   exc_view;
    csr_pkg::timer_view_t tmr_view;
    logic [1:0]           swi;

    csr_exc_regs u_exc_regs (
        .clk    (clk),
        .resetn (resetn),
        .wr     (wr),
        .evt    (evt),
        .view   (exc_view),
        .swi    (swi)
    );

    csr_timer u_timer (
        .clk    (clk),
        .resetn (resetn),
        .wr     (wr),
        .view   (tmr_view)
    );

    csr_read_mux u_read_mux (
        .raddr   (raddr),
        .exc     (exc_view),
        .swi     (swi),
        .tmr     (tmr_view),
        .rdata   (rdata),
        .has_int (has_int)
    );

    // Entry is always EENTRY, no refill vector
    assign exc_entaddr = exc_view.eentry;
    assign exc_retaddr = exc_view.era;

endmodule

//--- tests/csr_unit_tb_checks.svh
int err_count   = 0;
int check_count = 0;

logic [31:0] lfsr_state = 32'hca8ac86f;

// Galois LFSR, x^32 + x^22 + x^2 + x + 1, one step per bit
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    logic        out;
    val = '0;
    for (int i = 0; i < n; i++) begin
        out        = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out) begin
            lfsr_state = lfsr_state ^ 32'h80200003;
        end
        val = {val[30:0], out};
    end
    return val;
endfunction

task automatic check_word(
    input string                     name,
    input logic [csr_pkg::CSR_W-1:0] got,
    input logic [csr_pkg::CSR_W-1:0] exp
);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

task automatic check_flag(
    input string name,
    input logic  got,
    input logic  exp
);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("** Error: %s = %h, expected %h at %0t", name, got, exp, $time);
    end
endtask

//--- tests/csr_unit_tb.sv
module csr_unit_tb;

    typedef struct packed {
        csr_pkg::csr_wr_t          wr;
        csr_pkg::exc_evt_t         evt;
        csr_pkg::csr_addr_e        raddr;
        logic [csr_pkg::CSR_W-1:0] exp_rdata;
        logic                      exp_int;
    } step_t;

    logic                      clk = 1'b0;
    logic                      resetn;
    csr_pkg::csr_wr_t          wr;
    csr_pkg::exc_evt_t         evt;
    csr_pkg::csr_addr_e        raddr;
    logic [csr_pkg::CSR_W-1:0] rdata;
    logic                      has_int;
    logic [csr_pkg::CSR_W-1:0] exc_entaddr;
    logic [csr_pkg::CSR_W-1:0] exc_retaddr;

    step_t       steps[$];
    int          test_count = 0;
    int          test_errs  = 0;
    // ESTAT code fields left behind by the exception test
    logic [31:0] codes = '0;

    `include "csr_unit_tb_checks.svh"

    always #50 clk = ~clk;

    csr_unit u_dut (
        .clk         (clk),
        .resetn      (resetn),
        .wr          (wr),
        .evt         (evt),
        .raddr       (raddr),
        .rdata       (rdata),
        .has_int     (has_int),
        .exc_entaddr (exc_entaddr),
        .exc_retaddr (exc_retaddr)
    );

    function automatic csr_pkg::csr_wr_t write_cmd(
        input csr_pkg::csr_addr_e addr,
        input logic [31:0]        mask,
        input logic [31:0]        data
    );
        csr_pkg::csr_wr_t w;
        w.we   = 1'b1;
        w.addr = addr;
        w.mask = mask;
        w.data = data;
        return w;
    endfunction

    task automatic add_step(input csr_pkg::csr_wr_t w, input csr_pkg::exc_evt_t e,
                            input csr_pkg::csr_addr_e ra, input logic [31:0] er,
                            input logic ei);
        steps.push_back('{w, e, ra, er, ei});
    endtask

    task automatic read_step(input csr_pkg::csr_addr_e ra, input logic [31:0] er,
                             input logic ei);
        add_step('0, '0, ra, er, ei);
    endtask

    // Drive after the edge, sample late in the cycle
    task automatic run_table();
        step_t st;
        while (steps.size() > 0) begin
            st = steps.pop_front();
            @(posedge clk);
            #10;
            wr    = st.wr;
            evt   = st.evt;
            raddr = st.raddr;
            #70;
            check_word($sformatf("rdata[%h]", st.raddr), rdata, st.exp_rdata);
            check_flag("has_int", has_int, st.exp_int);
        end
        @(posedge clk);
        #10;
        wr  = '0;
        evt = '0;
    endtask

    task automatic report_test(input string name);
        test_count++;
        $display("test %0d %s: %0d errors", test_count, name, err_count - test_errs);
        test_errs = err_count;
    endtask

    task automatic wait_for_int(input int limit);
        int n;
        n = 0;
        while (has_int !== 1'b1 && n < limit) begin
            @(posedge clk);
            #80;
            n++;
        end
        if (has_int !== 1'b1) begin
            err_count++;
            $display("Timer interrupt did not rise within %0d cycles", limit);
        end
    endtask

    task automatic test_reset();
        csr_pkg::csr_addr_e addrs[$];
        addrs = {csr_pkg::CSR_CRMD, csr_pkg::CSR_PRMD, csr_pkg::CSR_ECFG, csr_pkg::CSR_ESTAT,
                 csr_pkg::CSR_ERA, csr_pkg::CSR_EENTRY, csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1,
                 csr_pkg::CSR_SAVE2, csr_pkg::CSR_SAVE3, csr_pkg::CSR_TID, csr_pkg::CSR_TCFG,
                 csr_pkg::CSR_TVAL, csr_pkg::CSR_TICLR, csr_pkg::csr_addr_e'(14'h007)};
        foreach (addrs[i]) begin
            read_step(addrs[i], (addrs[i] == csr_pkg::CSR_TVAL) ? '1 : '0, 1'b0);
        end
        run_table();
        report_test("reset values");
    endtask

    task automatic test_masked_writes();
        csr_pkg::csr_addr_e regs[$];
        logic [31:0] rmask [11] = '{32'h7, 32'h7, 32'h1fff, '1, 32'hffffffc0,
                                    '1, '1, '1, '1, '1, '1};
        logic [31:0] model [11] = '{default: '0};
        logic [31:0] m;
        logic [31:0] d;
        regs = {csr_pkg::CSR_CRMD, csr_pkg::CSR_PRMD, csr_pkg::CSR_ECFG, csr_pkg::CSR_ERA,
                csr_pkg::CSR_EENTRY, csr_pkg::CSR_SAVE0, csr_pkg::CSR_SAVE1, csr_pkg::CSR_SAVE2,
                csr_pkg::CSR_SAVE3, csr_pkg::CSR_TID, csr_pkg::CSR_TCFG};
        for (int r = 0; r < 2; r++) begin
            foreach (model[i]) begin
                m        = rand_bits(32);
                d        = rand_bits(32);
                model[i] = ((m & d) | (~m & model[i])) & rmask[i];
                add_step(write_cmd(regs[i], m, d), '0, csr_pkg::CSR_TICLR, '0, 1'b0);
                read_step(regs[i], model[i], 1'b0);
            end
        end
        m = rand_bits(32);
        d = rand_bits(32);
        add_step(write_cmd(csr_pkg::CSR_TICLR, m, d), '0, csr_pkg::CSR_TICLR, '0, 1'b0);
        read_step(csr_pkg::CSR_TICLR, '0, 1'b0);
        run_table();
        report_test("masked writes");
    endtask

    task automatic test_exception();
        csr_pkg::exc_evt_t e;
        csr_pkg::exc_evt_t ret;
        e          = '0;
        e.exc      = 1'b1;
        e.ecode    = 6'h0b;
        e.esubcode = 9'h1a5;
        e.pc       = 32'h1c00_1234;
        ret        = '0;
        ret.ertn   = 1'b1;
        codes = (32'(e.esubcode) << csr_pkg::ESTAT_ESUBCODE_LO)
                | (32'(e.ecode) << csr_pkg::ESTAT_ECODE_LO);
        add_step(write_cmd(csr_pkg::CSR_ECFG, '1, '0), '0, csr_pkg::CSR_TICLR, '0, 1'b0);
        add_step(write_cmd(csr_pkg::CSR_TCFG, '1, '0), '0, csr_pkg::CSR_TICLR, '0, 1'b0);
        add_step(write_cmd(csr_pkg::CSR_EENTRY, '1, 32'h1c00_8040), '0,
                 csr_pkg::CSR_TICLR, '0, 1'b0);
        add_step(write_cmd(csr_pkg::CSR_CRMD, '1, 32'h7), '0, csr_pkg::CSR_TICLR, '0, 1'b0);
        add_step('0, e, csr_pkg::CSR_CRMD, 32'h7, 1'b0);
        read_step(csr_pkg::CSR_CRMD, '0, 1'b0);
        read_step(csr_pkg::CSR_PRMD, 32'h7, 1'b0);
        read_step(csr_pkg::CSR_ERA, e.pc, 1'b0);
        read_step(csr_pkg::CSR_ESTAT, codes, 1'b0);
        add_step('0, ret, csr_pkg::CSR_EENTRY, 32'h1c00_8040, 1'b0);
        read_step(csr_pkg::CSR_CRMD, 32'h7, 1'b0);
        run_table();
        check_word("exc_retaddr", exc_retaddr, e.pc);
        check_word("exc_entaddr", exc_entaddr, 32'h1c00_8040);
        report_test("exception entry and return");
    endtask

    task automatic test_oneshot();
        add_step(write_cmd(csr_pkg::CSR_TCFG, '1, 32'h9), '0, csr_pkg::CSR_TCFG, '0, 1'b0);
        for (int n = 0; n <= 8; n++) begin
            read_step(csr_pkg::CSR_TVAL, 32'(8 - n), 1'b0);
        end
        read_step(csr_pkg::CSR_ESTAT, codes | 32'h800, 1'b0);
        read_step(csr_pkg::CSR_TVAL, '1, 1'b0);
        // Idle value holds
        read_step(csr_pkg::CSR_TVAL, '1, 1'b0);
        run_table();
        report_test("one-shot timer");
    endtask

    task automatic test_gating();
        add_step(write_cmd(csr_pkg::CSR_ECFG, '1, 32'h800), '0,
                 csr_pkg::CSR_ESTAT, codes | 32'h800, 1'b0);
        add_step(write_cmd(csr_pkg::CSR_CRMD, 32'h4, '0), '0, csr_pkg::CSR_ECFG, 32'h800, 1'b1);
        read_step(csr_pkg::CSR_CRMD, 32'h3, 1'b0);
        add_step(write_cmd(csr_pkg::CSR_CRMD, 32'h4, 32'h4), '0,
                 csr_pkg::CSR_ESTAT, codes | 32'h800, 1'b0);
        add_step(write_cmd(csr_pkg::CSR_TICLR, 32'h1, 32'h1), '0, csr_pkg::CSR_CRMD, 32'h7, 1'b1);
        read_step(csr_pkg::CSR_ESTAT, codes, 1'b0);
        // Software bits against their LIE bits
        add_step(write_cmd(csr_pkg::CSR_ESTAT, 32'h3, 32'h2), '0, csr_pkg::CSR_ESTAT, codes, 1'b0);
        add_step(write_cmd(csr_pkg::CSR_ECFG, 32'h3, 32'h2), '0,
                 csr_pkg::CSR_ESTAT, codes | 32'h2, 1'b0);
        add_step(write_cmd(csr_pkg::CSR_ESTAT, 32'h3, 32'h1), '0, csr_pkg::CSR_ECFG, 32'h802, 1'b1);
        read_step(csr_pkg::CSR_ESTAT, codes | 32'h1, 1'b0);
        add_step(write_cmd(csr_pkg::CSR_ECFG, 32'h3, 32'h1), '0, csr_pkg::CSR_ECFG, 32'h802, 1'b0);
        add_step(write_cmd(csr_pkg::CSR_ESTAT, 32'h3, '0), '0, csr_pkg::CSR_ECFG, 32'h801, 1'b1);
        read_step(csr_pkg::CSR_ESTAT, codes, 1'b0);
        run_table();
        wr = write_cmd(csr_pkg::CSR_TCFG, '1, 32'h5);
        @(posedge clk);
        #10;
        wr = '0;
        wait_for_int(20);
        @(posedge clk);
        #10;
        wr = write_cmd(csr_pkg::CSR_TICLR, 32'h1, 32'h1);
        @(posedge clk);
        #10;
        wr = '0;
        #70;
        check_flag("has_int", has_int, 1'b0);
        report_test("interrupt gating and clear");
    endtask

    task automatic test_periodic();
        add_step(write_cmd(csr_pkg::CSR_TCFG, '1, 32'h7), '0, csr_pkg::CSR_TCFG, 32'h5, 1'b0);
        for (int n = 4; n >= 0; n--) begin
            read_step(csr_pkg::CSR_TVAL, 32'(n), 1'b0);
        end
        read_step(csr_pkg::CSR_TVAL, 32'h4, 1'b1);
        read_step(csr_pkg::CSR_TVAL, 32'h3, 1'b1);
        add_step(write_cmd(csr_pkg::CSR_TICLR, 32'h1, 32'h1), '0, csr_pkg::CSR_TVAL, 32'h2, 1'b1);
        read_step(csr_pkg::CSR_TVAL, 32'h1, 1'b0);
        read_step(csr_pkg::CSR_TVAL, '0, 1'b0);
        read_step(csr_pkg::CSR_TVAL, 32'h4, 1'b1);
        add_step(write_cmd(csr_pkg::CSR_TCFG, '1, '0), '0, csr_pkg::CSR_TICLR, '0, 1'b1);
        run_table();
        report_test("periodic timer");
    endtask

    initial begin
        resetn = 1'b0;
        wr     = '0;
        evt    = '0;
        raddr  = csr_pkg::CSR_CRMD;
        for (int i = 0; i < 16; i++) begin
            @(posedge clk);
        end
        #10;
        resetn = 1'b1;
        test_reset();
        test_masked_writes();
        test_exception();
        test_oneshot();
        test_gating();
        test_periodic();
        $display("%0d tests, %0d checks, %0d errors", test_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

//--- csr_unit.f
+incdir+tests
hdl/csr_pkg.sv
hdl/csr_exc_regs.sv
hdl/csr_timer.sv
hdl/csr_read_mux.sv
hdl/csr_unit.sv
tests/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  - files:
      - hdl/csr_pkg.sv
      - hdl/csr_exc_regs.sv
      - hdl/csr_timer.sv
      - hdl/csr_read_mux.sv
      - hdl/csr_unit.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/csr_unit_tb.sv
